// File: Bender.yml
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_tag_store.sv
  - src/icache_data_store.sv
  - src/icache_ctrl.sv
  - src/icache_top.sv
  - target: simulation
    files:
      - testbench/tb_icache_checker.sv
      - testbench/tb_icache.sv

// File: all.f
src/icache_pkg.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_ctrl.sv
src/icache_top.sv
testbench/tb_icache_checker.sv
testbench/tb_icache.sv

// File: src/icache_ctrl.sv
// ==================================================
// icache controller: request accept, miss FSM,
// AXI read master, flush and response forming
// ==================================================
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  addr_t     req_pc,
    input  logic      flush,
    input  logic      hit,
    input  logic      hit_way,
    input  logic      victim_way,
    output logic      alloc,
    output logic      rd_en,
    input  inst_t     rd_inst,
    output logic      fill,
    output addr_t     fill_pc,
    output logic      fill_way,
    output logic      ar_valid,
    input  logic      ar_ready,
    output addr_t     ar_addr,
    input  logic      r_valid,
    output logic      r_ready,
    input  line_t     r_data,
    input  axi_resp_t r_resp,
    output logic      resp_valid,
    output inst_t     resp_inst,
    output logic      resp_error
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic  accept;
    logic  ar_hs;
    logic  r_hs;
    addr_t miss_addr_q;
    logic  miss_way_q;
    logic  miss_hi_q;
    logic  drop_q;
    logic  resp_pend_q;
    logic  resp_hit_q;
    inst_t refill_inst_q;
    logic  refill_err_q;

    assign req_ready = (state_q == IDLE) && !flush;
    assign accept    = req_valid && req_ready;
    assign ar_hs     = ar_valid && ar_ready;
    assign r_hs      = r_valid && r_ready;

    assign rd_en     = accept && hit;
    assign alloc     = accept && !hit;

    // ==================================================
    // miss FSM
    // ==================================================
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (alloc) begin
                    state_d = ADDR;
                end
            end
            ADDR: begin
                if (ar_hs) begin
                    state_d = DATA;
                end
            end
            DATA: begin
                if (r_hs) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // line address, way and word of the outstanding miss
    always_ff @(posedge clk) begin
        if (alloc) begin
            miss_addr_q <= {req_pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            miss_way_q  <= victim_way;
            miss_hi_q   <= req_pc[2];
        end
    end

    // ==================================================
    // AXI AR / R
    // ==================================================
    assign ar_valid = (state_q == ADDR);
    assign ar_addr  = miss_addr_q;
    assign r_ready  = (state_q == DATA);

    assign fill     = r_hs && (r_resp == AXI_OKAY);
    assign fill_pc  = miss_addr_q;
    assign fill_way = miss_way_q;

    always_ff @(posedge clk) begin
        if (r_hs) begin
            refill_inst_q <= miss_hi_q ? r_data[LINE_W-1:INST_W] : r_data[INST_W-1:0];
            refill_err_q  <= (r_resp != AXI_OKAY);
        end
    end

    // flush during a miss lets the bus finish but mutes the answer
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_q <= 1'b0;
        end else if (r_hs) begin
            drop_q <= 1'b0;
        end else if (flush && (state_q != IDLE)) begin
            drop_q <= 1'b1;
        end
    end

    // ==================================================
    // response
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_pend_q <= 1'b0;
            resp_hit_q  <= 1'b0;
        end else begin
            resp_pend_q <= rd_en || (r_hs && !drop_q && !flush);
            resp_hit_q  <= rd_en;
        end
    end

    assign resp_valid = resp_pend_q && !flush;
    assign resp_inst  = resp_hit_q ? rd_inst : refill_inst_q;
    assign resp_error = resp_valid && !resp_hit_q && refill_err_q;

    assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ctrl: AR dropped or changed before ar_ready");

    assert property (@(posedge clk) disable iff (rst) flush |=> !resp_valid)
        else $error("ctrl: response after flush");

endmodule

// File: src/icache_data_store.sv
// ==================================================
// icache line storage for both ways, 1-cycle read
// with addressed word select
// ==================================================
`timescale 1ns/1ps

module icache_data_store import icache_pkg::*; #(
    parameter int NUM_SETS = 256
) (
    input  logic  clk,
    input  logic  rd_en,
    input  addr_t rd_pc,
    input  logic  rd_way,
    output inst_t rd_inst,
    input  logic  wr_en,
    input  addr_t wr_pc,
    input  logic  wr_way,
    input  line_t wr_line
);

    localparam int IDX_W = $clog2(NUM_SETS);

    typedef logic [IDX_W-1:0] idx_t;

    line_t line_mem [2][NUM_SETS];

    idx_t  rd_idx;
    idx_t  wr_idx;
    line_t rd_line_q;
    logic  rd_hi_q;

    assign rd_idx = rd_pc[OFFSET_W +: IDX_W];
    assign wr_idx = wr_pc[OFFSET_W +: IDX_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_way][wr_idx] <= wr_line;
        end
    end

    // bit 2 picks the upper word of the line
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_line_q <= line_mem[rd_way][rd_idx];
            rd_hi_q   <= rd_pc[2];
        end
    end

    assign rd_inst = rd_hi_q ? rd_line_q[LINE_W-1:INST_W] : rd_line_q[INST_W-1:0];

endmodule

// File: src/icache_pkg.sv
// ==================================================
// icache shared widths, vector types, controller
// states and AXI read response codes
// ==================================================
package icache_pkg;

    localparam int ADDR_W   = 32;
    localparam int INST_W   = 32;
    localparam int LINE_W   = 64;
    localparam int RESP_W   = 2;

    // byte offset bits inside one 8-byte line
    localparam int OFFSET_W = 3;

    // ==================================================
    // vector types
    // ==================================================
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [RESP_W-1:0] axi_resp_t;

    // AXI4 xRESP encodings
    localparam axi_resp_t AXI_OKAY   = 2'b00;
    localparam axi_resp_t AXI_EXOKAY = 2'b01;
    localparam axi_resp_t AXI_SLVERR = 2'b10;
    localparam axi_resp_t AXI_DECERR = 2'b11;

    // ==================================================
    // miss FSM
    // ==================================================
    typedef enum logic [1:0] {
        // accepting requests
        IDLE,
        // AR pending
        ADDR,
        // waiting for R beat
        DATA
    } ctrl_state_e;

endpackage

// File: src/icache_tag_store.sv
// ==================================================
// icache tag and valid arrays, hit compare,
// per-set replacement bit and victim choice
// ==================================================
`timescale 1ns/1ps

module icache_tag_store import icache_pkg::*; #(
    parameter int NUM_SETS = 256
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t lookup_pc,
    output logic  hit,
    output logic  hit_way,
    output logic  victim_way,
    input  logic  alloc,
    input  logic  fill,
    input  addr_t fill_pc,
    input  logic  fill_way
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    tag_t tag_mem [2][NUM_SETS];
    logic valid_q [2][NUM_SETS];
    // way chosen at the last allocation of each set
    logic repl_q  [NUM_SETS];
    logic alloc_pend_q;

    idx_t lookup_idx;
    tag_t lookup_tag;
    idx_t fill_idx;
    tag_t fill_tag;
    logic hit0;
    logic hit1;

    assign lookup_idx = lookup_pc[OFFSET_W +: IDX_W];
    assign lookup_tag = lookup_pc[ADDR_W-1 -: TAG_W];
    assign fill_idx   = fill_pc[OFFSET_W +: IDX_W];
    assign fill_tag   = fill_pc[ADDR_W-1 -: TAG_W];

    // ==================================================
    // lookup, way 0 has priority
    // ==================================================
    assign hit0    = valid_q[0][lookup_idx] && (tag_mem[0][lookup_idx] == lookup_tag);
    assign hit1    = valid_q[1][lookup_idx] && (tag_mem[1][lookup_idx] == lookup_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = !hit0;

    always_comb begin
        if (!valid_q[0][lookup_idx]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][lookup_idx]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = !repl_q[lookup_idx];
        end
    end

    // ==================================================
    // state update
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[0][s] <= 1'b0;
                valid_q[1][s] <= 1'b0;
                repl_q[s]     <= 1'b0;
            end
            alloc_pend_q <= 1'b0;
        end else begin
            if (alloc) begin
                repl_q[lookup_idx] <= victim_way;
                alloc_pend_q       <= 1'b1;
            end
            if (fill) begin
                valid_q[fill_way][fill_idx] <= 1'b1;
                alloc_pend_q                <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[fill_way][fill_idx] <= fill_tag;
        end
    end

    // a line is never installed twice in one set
    assert property (@(posedge clk) disable iff (rst) !(hit0 && hit1))
        else $error("tag store: both ways hit");

    assert property (@(posedge clk) disable iff (rst) fill |-> alloc_pend_q)
        else $error("tag store: fill without prior alloc");

endmodule

// File: src/icache_top.sv
// ==================================================
// icache top: controller, tag store, data store
// ==================================================
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int NUM_SETS = 256
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  addr_t     req_pc,
    input  logic      flush,
    output logic      resp_valid,
    output inst_t     resp_inst,
    output logic      resp_error,
    output logic      ar_valid,
    input  logic      ar_ready,
    output addr_t     ar_addr,
    input  logic      r_valid,
    output logic      r_ready,
    input  line_t     r_data,
    input  axi_resp_t r_resp
);

    logic  hit;
    logic  hit_way;
    logic  victim_way;
    logic  alloc;
    logic  rd_en;
    inst_t rd_inst;
    logic  fill;
    addr_t fill_pc;
    logic  fill_way;

    icache_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_pc     (req_pc),
        .flush      (flush),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .alloc      (alloc),
        .rd_en      (rd_en),
        .rd_inst    (rd_inst),
        .fill       (fill),
        .fill_pc    (fill_pc),
        .fill_way   (fill_way),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r_data     (r_data),
        .r_resp     (r_resp),
        .resp_valid (resp_valid),
        .resp_inst  (resp_inst),
        .resp_error (resp_error)
    );

    icache_tag_store #(
        .NUM_SETS (NUM_SETS)
    ) tag_store_i (
        .clk        (clk),
        .rst        (rst),
        .lookup_pc  (req_pc),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .alloc      (alloc),
        .fill       (fill),
        .fill_pc    (fill_pc),
        .fill_way   (fill_way)
    );

    // refill beat goes straight into the line array
    icache_data_store #(
        .NUM_SETS (NUM_SETS)
    ) data_store_i (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_pc   (req_pc),
        .rd_way  (hit_way),
        .rd_inst (rd_inst),
        .wr_en   (fill),
        .wr_pc   (fill_pc),
        .wr_way  (fill_way),
        .wr_line (r_data)
    );

endmodule

// File: testbench/tb_icache.sv
// ==================================================
// icache testbench: clock, reset, fetch stimulus,
// flush injection, AXI read slave and timeout
// ==================================================
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

    localparam int NUM_SETS       = 8;
    localparam int NUM_REQS       = 2000;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 16 + 100;
    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;

    logic      clk = 1'b0;
    logic      rst;
    logic      req_valid;
    logic      req_ready;
    addr_t     req_pc;
    logic      flush;
    logic      resp_valid;
    inst_t     resp_inst;
    logic      resp_error;
    logic      ar_valid;
    logic      ar_ready;
    addr_t     ar_addr;
    logic      r_valid;
    logic      r_ready;
    line_t     r_data;
    axi_resp_t r_resp;
    int        error_count;
    int        check_count;
    int        cycle_count = 0;
    int        accepted;
    logic      took;
    addr_t     slave_addr;

    icache_top #(.NUM_SETS(NUM_SETS)) icache_top_i (.*);
    tb_icache_checker #(.NUM_SETS(NUM_SETS)) checker_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // 3 tags x 8 sets x 2 words
    function automatic addr_t random_pc();
        addr_t pc;
        pc      = '0;
        pc[7:6] = $urandom_range(2);
        pc[5:3] = $urandom_range(7);
        pc[2]   = $urandom_range(1);
        return pc;
    endfunction

    // memory image seen by the slave
    function automatic line_t line_data(addr_t a);
        return {(a + 32'd4) ^ 32'h5a5a0000, a ^ 32'h5a5a0000};
    endfunction

    function automatic axi_resp_t slave_resp(addr_t a);
        return (a[5:3] == 3'd7 && (a >> 6) == 32'd2) ? AXI_SLVERR : AXI_OKAY;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // ==================================================
    // fetch stimulus
    // ==================================================
    initial begin
        void'($urandom(32'h09f4c17a));
        rst       = 1'b1;
        req_valid = 1'b0;
        req_pc    = '0;
        flush     = 1'b0;
        accepted  = 0;
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        while (accepted < NUM_REQS) begin
            @(posedge clk);
            took = req_valid && req_ready;
            #DRIVE_DELAY;
            if (took) begin
                accepted++;
            end
            flush = ($urandom_range(99) < 3);
            // pc held until accepted
            if (took || !req_valid) begin
                req_valid = ($urandom_range(3) != 0) && (accepted < NUM_REQS);
                req_pc    = random_pc();
            end
        end
        req_valid = 1'b0;
        flush     = 1'b0;
        do @(posedge clk); while (!req_ready);
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ==================================================
    // AXI read slave, one beat per AR
    // ==================================================
    initial begin
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r_data     = '0;
        r_resp     = AXI_OKAY;
        slave_addr = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (ar_valid) begin
                slave_addr = ar_addr;
                wait_cycles($urandom_range(6));
                ar_ready = 1'b1;
                wait_cycles(1);
                ar_ready = 1'b0;
                wait_cycles($urandom_range(6));
                r_valid = 1'b1;
                r_data  = line_data(slave_addr);
                r_resp  = slave_resp(slave_addr);
                wait_cycles(1);
                r_valid = 1'b0;
            end
        end
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles, %0d of %0d requests accepted",
                 TIMEOUT_CYCLES, accepted, NUM_REQS);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: testbench/tb_icache_checker.sv
// ==================================================
// icache reference model and response checks
// ==================================================
`timescale 1ns/1ps

module tb_icache_checker import icache_pkg::*; #(
    parameter int NUM_SETS = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  logic      req_ready,
    input  addr_t     req_pc,
    input  logic      flush,
    input  logic      resp_valid,
    input  inst_t     resp_inst,
    input  logic      resp_error,
    input  logic      ar_valid,
    input  logic      ar_ready,
    input  addr_t     ar_addr,
    input  logic      r_valid,
    input  logic      r_ready,
    output int        error_count,
    output int        check_count
);

    localparam int IDX_W = $clog2(NUM_SETS);

    addr_t m_tag   [2][NUM_SETS];
    logic  m_valid [2][NUM_SETS];
    logic  m_repl  [NUM_SETS];

    // outstanding miss and the answer due next cycle
    logic  miss_busy;
    logic  addr_phase;
    logic  data_phase;
    logic  miss_drop;
    logic  miss_way;
    addr_t miss_pc;
    logic  due_valid;
    logic  due_err;
    addr_t due_pc;

    function automatic logic slverr_line(addr_t a);
        return (a[5:3] == 3'd7) && ((a >> 6) == 32'd2);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    always @(posedge clk) begin
        int   s;
        logic hit0;
        logic hit1;
        logic victim;
        if (rst) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                m_valid[0][i] = 1'b0;
                m_valid[1][i] = 1'b0;
                m_repl[i]     = 1'b0;
            end
            {miss_busy, addr_phase, data_phase, miss_drop, due_valid} = '0;
            error_count = 0;
            check_count = 0;
        end else begin
            compare_value("resp_valid", resp_valid, due_valid && !flush);
            if (due_valid && !flush && resp_valid) begin
                compare_value("resp_error", resp_error, due_err);
                if (!due_err) begin
                    compare_value("resp_inst", resp_inst, due_pc ^ 32'h5a5a0000);
                end
            end
            due_valid = 1'b0;
            compare_value("req_ready", req_ready, !miss_busy && !flush);
            compare_value("ar_valid", ar_valid, addr_phase);
            compare_value("r_ready", r_ready, data_phase);
            if (miss_busy && flush) begin
                miss_drop = 1'b1;
            end
            if (addr_phase && ar_valid) begin
                compare_value("ar_addr", ar_addr, {miss_pc[31:3], 3'b000});
                if (ar_ready) begin
                    addr_phase = 1'b0;
                    data_phase = 1'b1;
                end
            end else if (data_phase && r_valid && r_ready) begin
                s = (miss_pc >> OFFSET_W) % NUM_SETS;
                // error lines stay out of the cache
                if (!slverr_line(miss_pc)) begin
                    m_tag[miss_way][s]   = miss_pc >> (OFFSET_W + IDX_W);
                    m_valid[miss_way][s] = 1'b1;
                end
                due_valid  = !miss_drop && !flush;
                due_pc     = miss_pc;
                due_err    = slverr_line(miss_pc);
                miss_busy  = 1'b0;
                data_phase = 1'b0;
            end
            if (req_valid && req_ready) begin
                s    = (req_pc >> OFFSET_W) % NUM_SETS;
                hit0 = m_valid[0][s] && m_tag[0][s] == (req_pc >> (OFFSET_W + IDX_W));
                hit1 = m_valid[1][s] && m_tag[1][s] == (req_pc >> (OFFSET_W + IDX_W));
                if (hit0 || hit1) begin
                    due_valid = 1'b1;
                    due_pc    = req_pc;
                    due_err   = 1'b0;
                end else begin
                    victim     = !m_valid[0][s] ? 1'b0 : !m_valid[1][s] ? 1'b1 : !m_repl[s];
                    m_repl[s]  = victim;
                    miss_way   = victim;
                    miss_pc    = req_pc;
                    miss_busy  = 1'b1;
                    addr_phase = 1'b1;
                    miss_drop  = 1'b0;
                end
            end
        end
    end

endmodule
